// ==== rtl/csa_pkg.sv ====
package csa_pkg;

	localparam int DATA_W = 32;
	localparam int IN_BYTES = 5;
	localparam int IN_W = 8 * IN_BYTES;
	localparam int ACC_W = 40;
	localparam int OUT_W = 48;

	// a job carries the target unit index next to the raw record.
	typedef struct packed {
		logic [7:0] channel;
		logic [IN_W-1:0] data;
	} csa_job_t;

	// also the word written to the output FIFO.
	typedef struct packed {
		logic [7:0] channel;
		logic [ACC_W-1:0] acc;
	} csa_result_t;

	typedef enum logic [3:0] {
		CHANNEL = 4'd0,
		IN_VALID = 4'd1,
		OUT_VALID = 4'd2,
		IN_DATA_0 = 4'd3,
		IN_DATA_1 = 4'd4,
		IN_DATA_2 = 4'd5,
		IN_DATA_3 = 4'd6,
		IN_DATA_4 = 4'd7,
		OUT_ACC_LO = 4'd8,
		OUT_ACC_HI = 4'd9
	} csa_reg_addr_e;

	typedef enum logic [1:0] {
		WAIT_IN,
		WAIT_OUT,
		HOLD
	} csa_valid_state_e;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		RESOLVE
	} csa_unit_state_e;

endpackage

// ==== rtl/csa_calc_unit.sv ====
module csa_calc_unit #(
	parameter int ID = 0,
	parameter int CALC_TIMES = 50000
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input csa_pkg::csa_job_t job,
	output logic busy,
	output logic done,
	output csa_pkg::csa_result_t result
);

	localparam int CNT_W = (CALC_TIMES > 1) ? $clog2(CALC_TIMES) : 1;

	csa_pkg::csa_unit_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [csa_pkg::ACC_W-1:0] byte_sum;
	logic [csa_pkg::ACC_W-1:0] term;
	logic [csa_pkg::ACC_W-1:0] sum_v;
	logic [csa_pkg::ACC_W-1:0] carry_v;

	always_comb begin
		byte_sum = '0;
		for (int k = 0; k < csa_pkg::IN_BYTES; k++) begin
			byte_sum = byte_sum + csa_pkg::ACC_W'(job.data[8*k +: 8]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= csa_pkg::IDLE;
			cnt <= '0;
		end else begin
			case (state)
				csa_pkg::IDLE: begin
					if (start) begin
						state <= csa_pkg::RUN;
						cnt <= '0;
					end
				end
				csa_pkg::RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(CALC_TIMES - 1)) begin
						state <= csa_pkg::RESOLVE;
					end
				end
				csa_pkg::RESOLVE: begin
					state <= csa_pkg::IDLE;
				end
				default: begin
					state <= csa_pkg::IDLE;
				end
			endcase
		end
	end

	// one 3:2 compression per RUN cycle keeps the carry chain out of the loop.
	always_ff @(posedge clk) begin
		if (start && state == csa_pkg::IDLE) begin
			term <= byte_sum;
			sum_v <= '0;
			carry_v <= '0;
		end else if (state == csa_pkg::RUN) begin
			sum_v <= sum_v ^ carry_v ^ term;
			carry_v <= ((sum_v & carry_v) | (sum_v & term) | (carry_v & term)) << 1;
		end
	end

	assign busy = (state != csa_pkg::IDLE);
	assign done = (state == csa_pkg::RESOLVE);
	assign result.channel = 8'(ID);
	// the only full-width add happens here, once per job.
	assign result.acc = sum_v + carry_v;

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

	a_job_channel: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> job.channel == 8'(ID));

endmodule

// ==== rtl/csa_dispatch.sv ====
module csa_dispatch #(
	parameter int NUM_UNITS = 5
) (
	input logic clk,
	input logic rst_n,
	input logic in_ready,
	output logic in_ren,
	input logic [csa_pkg::IN_W-1:0] in_rdata,
	input logic [NUM_UNITS-1:0] unit_busy,
	output logic [NUM_UNITS-1:0] start,
	output csa_pkg::csa_job_t job,
	output logic job_seen
);

	localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

	typedef enum logic [1:0] {
		D_IDLE,
		D_READ,
		D_ISSUE
	} disp_state_e;

	disp_state_e state;
	logic [IDX_W-1:0] idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= D_IDLE;
			idx <= '0;
			in_ren <= 1'b0;
			start <= '0;
			job_seen <= 1'b0;
		end else begin
			in_ren <= 1'b0;
			start <= '0;
			job_seen <= 1'b0;
			case (state)
				D_IDLE: begin
					// the start bit still counts, busy rises only a cycle later.
					if (in_ready && !unit_busy[idx] && !start[idx]) begin
						in_ren <= 1'b1;
						state <= D_READ;
					end
				end
				D_READ: begin
					state <= D_ISSUE;
				end
				D_ISSUE: begin
					start[idx] <= 1'b1;
					job_seen <= 1'b1;
					idx <= (idx == IDX_W'(NUM_UNITS - 1)) ? '0 : idx + 1'b1;
					state <= D_IDLE;
				end
				default: begin
					state <= D_IDLE;
				end
			endcase
		end
	end

	// the FIFO word is valid one cycle after the read pulse.
	always_ff @(posedge clk) begin
		if (state == D_ISSUE) begin
			job.channel <= 8'(idx);
			job.data <= in_rdata;
		end
	end

endmodule

// ==== rtl/csa_collect.sv ====
module csa_collect #(
	parameter int NUM_UNITS = 5
) (
	input logic clk,
	input logic rst_n,
	input logic [NUM_UNITS-1:0] unit_done,
	input csa_pkg::csa_result_t unit_result [NUM_UNITS],
	output logic out_wen,
	output csa_pkg::csa_result_t out_wdata,
	output logic result_seen
);

	logic [csa_pkg::OUT_W-1:0] merged;

	// completions are one-hot, so an OR of the masked results is the mux.
	always_comb begin
		merged = '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (unit_done[i]) begin
				merged = merged | unit_result[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_wen <= 1'b0;
		end else begin
			out_wen <= |unit_done;
		end
	end

	always_ff @(posedge clk) begin
		if (|unit_done) begin
			out_wdata <= merged;
		end
	end

	assign result_seen = out_wen;

	a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(unit_done));

	// issue spacing in the dispatcher keeps writes apart.
	a_write_gap: assert property (@(posedge clk) disable iff (!rst_n)
		out_wen |=> !out_wen);

endmodule

// ==== rtl/csa_reg_port.sv ====
module csa_reg_port #(
	parameter int NUM_UNITS = 5,
	parameter int ADDR_BITS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input logic [ADDR_BITS-1:0] waddr,
	input logic [csa_pkg::DATA_W-1:0] wdata,
	input logic [csa_pkg::DATA_W/8-1:0] wstrb,
	input logic ren,
	input logic [ADDR_BITS-1:0] raddr,
	output logic [csa_pkg::DATA_W-1:0] rdata,
	input logic job_seen,
	input csa_pkg::csa_job_t job,
	input logic result_seen,
	input csa_pkg::csa_result_t result
);

	localparam logic [csa_pkg::DATA_W-1:0] UNIT_LIMIT = NUM_UNITS;

	logic [ADDR_BITS-1:0] wr_addr;
	logic [csa_pkg::DATA_W-1:0] wr_data;
	logic wr_pend;
	logic chan_load;
	logic [7:0] channel;
	logic in_hit;
	logic out_hit;
	logic [csa_pkg::IN_W-1:0] in_snap;
	csa_pkg::csa_result_t out_snap;
	csa_pkg::csa_valid_state_e vstate;
	logic in_valid;
	logic out_valid;
	logic [csa_pkg::DATA_W-1:0] rd_word;

	// bytes with a low strobe keep their previous value.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_addr <= '0;
			wr_data <= '0;
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= wen;
			if (wen) begin
				wr_addr <= waddr;
				for (int b = 0; b < csa_pkg::DATA_W / 8; b++) begin
					if (wstrb[b]) begin
						wr_data[8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end
		end
	end

	assign chan_load = wr_pend && (wr_addr == ADDR_BITS'(csa_pkg::CHANNEL))
		&& (wr_data < UNIT_LIMIT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			channel <= '0;
		end else if (chan_load) begin
			channel <= wr_data[7:0];
		end
	end

	// captures against the old channel are dropped in the cycle it changes.
	assign in_hit = job_seen && (job.channel == channel) && !chan_load;
	assign out_hit = result_seen && (result.channel == channel) && !chan_load;

	always_ff @(posedge clk) begin
		if (in_hit) begin
			in_snap <= job.data;
		end
		if (out_hit) begin
			out_snap <= result;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vstate <= csa_pkg::WAIT_IN;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (chan_load) begin
			vstate <= csa_pkg::WAIT_IN;
			in_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			case (vstate)
				csa_pkg::WAIT_IN: begin
					if (in_hit) begin
						in_valid <= 1'b1;
						vstate <= csa_pkg::WAIT_OUT;
					end
				end
				csa_pkg::WAIT_OUT: begin
					if (out_hit) begin
						out_valid <= 1'b1;
						vstate <= csa_pkg::HOLD;
					end
				end
				csa_pkg::HOLD: begin
					vstate <= csa_pkg::HOLD;
				end
				default: begin
					vstate <= csa_pkg::WAIT_IN;
				end
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (raddr)
			ADDR_BITS'(csa_pkg::CHANNEL): rd_word[7:0] = channel;
			ADDR_BITS'(csa_pkg::IN_VALID): rd_word[0] = in_valid;
			ADDR_BITS'(csa_pkg::OUT_VALID): rd_word[0] = out_valid;
			ADDR_BITS'(csa_pkg::IN_DATA_0): rd_word[7:0] = in_snap[7:0];
			ADDR_BITS'(csa_pkg::IN_DATA_1): rd_word[7:0] = in_snap[15:8];
			ADDR_BITS'(csa_pkg::IN_DATA_2): rd_word[7:0] = in_snap[23:16];
			ADDR_BITS'(csa_pkg::IN_DATA_3): rd_word[7:0] = in_snap[31:24];
			ADDR_BITS'(csa_pkg::IN_DATA_4): rd_word[7:0] = in_snap[39:32];
			ADDR_BITS'(csa_pkg::OUT_ACC_LO): rd_word = out_snap.acc[31:0];
			ADDR_BITS'(csa_pkg::OUT_ACC_HI): rd_word[15:0] = {out_snap.channel, out_snap.acc[39:32]};
			default: rd_word = {16'hE000, 16'(raddr)};
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			rdata <= rd_word;
		end
	end

endmodule

// ==== rtl/csa_top.sv ====
module csa_top #(
	parameter int NUM_UNITS = 5,
	parameter int CALC_TIMES = 50000,
	parameter int ADDR_BITS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input logic [ADDR_BITS-1:0] waddr,
	input logic [csa_pkg::DATA_W-1:0] wdata,
	input logic [csa_pkg::DATA_W/8-1:0] wstrb,
	input logic ren,
	input logic [ADDR_BITS-1:0] raddr,
	output logic [csa_pkg::DATA_W-1:0] rdata,
	input logic in_ready,
	output logic in_ren,
	input logic [csa_pkg::IN_W-1:0] in_rdata,
	output logic out_wen,
	output csa_pkg::csa_result_t out_wdata
);

	logic [NUM_UNITS-1:0] unit_busy;
	logic [NUM_UNITS-1:0] unit_start;
	logic [NUM_UNITS-1:0] unit_done;
	csa_pkg::csa_result_t unit_result [NUM_UNITS];
	csa_pkg::csa_job_t job;
	logic job_seen;
	logic result_seen;

	csa_reg_port #(
		.NUM_UNITS(NUM_UNITS),
		.ADDR_BITS(ADDR_BITS)
	) reg_port_i (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.job_seen(job_seen),
		.job(job),
		.result_seen(result_seen),
		.result(out_wdata)
	);

	csa_dispatch #(
		.NUM_UNITS(NUM_UNITS)
	) dispatch_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_ready(in_ready),
		.in_ren(in_ren),
		.in_rdata(in_rdata),
		.unit_busy(unit_busy),
		.start(unit_start),
		.job(job),
		.job_seen(job_seen)
	);

	// all units see the same job bus, only the one with its start bit takes it.
	for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
		csa_calc_unit #(
			.ID(i),
			.CALC_TIMES(CALC_TIMES)
		) calc_unit_i (
			.clk(clk),
			.rst_n(rst_n),
			.start(unit_start[i]),
			.job(job),
			.busy(unit_busy[i]),
			.done(unit_done[i]),
			.result(unit_result[i])
		);
	end

	csa_collect #(
		.NUM_UNITS(NUM_UNITS)
	) collect_i (
		.clk(clk),
		.rst_n(rst_n),
		.unit_done(unit_done),
		.unit_result(unit_result),
		.out_wen(out_wen),
		.out_wdata(out_wdata),
		.result_seen(result_seen)
	);

endmodule

// ==== verif/csa_tb.sv ====
module csa_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_UNITS = 5;
	localparam int CALC_TIMES = 6;
	localparam int ADDR_BITS = 4;
	localparam int NUM_RECORDS = 40;
	localparam int EXTRA_RECORDS = 10;
	localparam int WAIT_LIMIT = 2000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic wen = 1'b0;
	logic [ADDR_BITS-1:0] waddr = '0;
	logic [csa_pkg::DATA_W-1:0] wdata = '0;
	logic [3:0] wstrb = '0;
	logic ren = 1'b0;
	logic [ADDR_BITS-1:0] raddr = '0;
	logic [csa_pkg::DATA_W-1:0] rdata;
	logic in_ready = 1'b0;
	logic in_ren;
	logic [csa_pkg::IN_W-1:0] in_rdata = '0;
	logic out_wen;
	csa_pkg::csa_result_t out_wdata;

	integer seed = 32'hb5da0b0c;
	logic [csa_pkg::IN_W-1:0] rec_pool [NUM_RECORDS + EXTRA_RECORDS];
	logic [csa_pkg::IN_W-1:0] in_q [$];
	csa_pkg::csa_result_t exp_q [$];
	logic [csa_pkg::IN_W-1:0] pend_rec;
	logic pend_valid = 1'b0;
	int sent_count = 0;
	int out_count = 0;
	logic [csa_pkg::IN_W-1:0] last_ch2_rec;
	csa_pkg::csa_result_t last_ch2_res;

	csa_top #(
		.NUM_UNITS(NUM_UNITS),
		.CALC_TIMES(CALC_TIMES),
		.ADDR_BITS(ADDR_BITS)
	) csa_top_i (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.in_ready(in_ready), .in_ren(in_ren), .in_rdata(in_rdata),
		.out_wen(out_wen), .out_wdata(out_wdata)
	);

	always #50 clk = ~clk;

	// each unit adds its byte sum CALC_TIMES times and the channel follows the rotation.
	function automatic csa_pkg::csa_result_t ref_result(input logic [39:0] rec, input int idx);
		csa_pkg::csa_result_t r;
		int sum;
		sum = 0;
		for (int k = 0; k < 5; k++) begin
			sum += int'(rec[8*k +: 8]);
		end
		r.channel = 8'(idx % NUM_UNITS);
		r.acc = 40'(CALC_TIMES * sum);
		return r;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_result(input string name, input csa_pkg::csa_result_t got,
		input csa_pkg::csa_result_t exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [csa_pkg::DATA_W-1:0] got,
		input logic [csa_pkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// the input FIFO model presents the popped record one cycle after the read pulse.
	always @(negedge clk) begin
		if (pend_valid) begin
			in_rdata = pend_rec;
			pend_valid = 1'b0;
		end
		if (in_ren === 1'b1) begin
			if (in_q.size() == 0) begin
				report_failure("input FIFO read while it was empty");
			end
			pend_rec = in_q.pop_front();
			pend_valid = 1'b1;
		end
		in_ready = (in_q.size() != 0) && (($random(seed) & 3) != 0);
	end

	always @(negedge clk) begin
		if (rst_n && out_wen === 1'b1) begin
			if (exp_q.size() == 0) begin
				report_failure("output FIFO written with no job outstanding");
			end
			check_result("out_wdata", out_wdata, exp_q.pop_front());
			out_count++;
		end
	end

	task automatic push_records(input int first, input int count);
		csa_pkg::csa_result_t res;
		@(posedge clk);
		for (int i = first; i < first + count; i++) begin
			res = ref_result(rec_pool[i], sent_count);
			in_q.push_back(rec_pool[i]);
			exp_q.push_back(res);
			if (res.channel == 8'd2) begin
				last_ch2_rec = rec_pool[i];
				last_ch2_res = res;
			end
			sent_count++;
		end
	endtask

	task automatic wait_outputs(input int total);
		int cyc;
		cyc = 0;
		while (out_count < total) begin
			@(negedge clk);
			cyc++;
			if (cyc > WAIT_LIMIT) begin
				report_failure($sformatf("timeout, only %0d of %0d results came out",
					out_count, total));
			end
		end
	endtask

	task automatic reg_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
		@(negedge clk);
		wen = 1'b1;
		waddr = ADDR_BITS'(addr);
		wdata = data;
		wstrb = strb;
		@(negedge clk);
		wen = 1'b0;
	endtask

	task automatic reg_read(input int addr, output logic [31:0] data);
		@(negedge clk);
		ren = 1'b1;
		raddr = ADDR_BITS'(addr);
		@(negedge clk);
		ren = 1'b0;
		data = rdata;
	endtask

	task automatic wait_flag(input int addr, input string name);
		logic [31:0] word;
		int tries;
		tries = 0;
		reg_read(addr, word);
		while (word[0] !== 1'b1) begin
			tries++;
			if (tries > WAIT_LIMIT) begin
				report_failure({"timeout waiting for ", name, " to read 1"});
			end
			reg_read(addr, word);
		end
		check_word({"rdata ", name}, word, 32'h1);
	endtask

	initial begin
		logic [31:0] word;
		for (int i = 0; i < NUM_RECORDS + EXTRA_RECORDS; i++) begin
			rec_pool[i] = {8'($random(seed)), 32'($random(seed))};
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		reg_read(csa_pkg::CHANNEL, word);
		check_word("rdata CHANNEL", word, 32'h0);
		reg_read(csa_pkg::IN_VALID, word);
		check_word("rdata IN_VALID", word, 32'h0);
		reg_read(csa_pkg::OUT_VALID, word);
		check_word("rdata OUT_VALID", word, 32'h0);
		repeat (20) begin
			@(negedge clk);
			check_flag("out_wen", out_wen, 1'b0);
		end

		push_records(0, NUM_RECORDS);
		wait_outputs(NUM_RECORDS);
		// a late duplicate would be caught by the output checker here.
		repeat (30) @(negedge clk);

		// upper bytes first, then byte 0 alone.
		reg_write(csa_pkg::CHANNEL, 32'h0000_00ff, 4'b1110);
		reg_write(csa_pkg::CHANNEL, 32'hdead_be03, 4'b0001);
		reg_read(csa_pkg::CHANNEL, word);
		check_word("rdata CHANNEL", word, 32'h3);
		reg_write(csa_pkg::CHANNEL, 32'h7, 4'b1111);
		reg_read(csa_pkg::CHANNEL, word);
		check_word("rdata CHANNEL", word, 32'h3);

		reg_write(csa_pkg::CHANNEL, 32'h2, 4'b1111);
		reg_read(csa_pkg::IN_VALID, word);
		check_word("rdata IN_VALID", word, 32'h0);
		push_records(NUM_RECORDS, EXTRA_RECORDS);
		wait_flag(csa_pkg::IN_VALID, "IN_VALID");
		wait_flag(csa_pkg::OUT_VALID, "OUT_VALID");
		wait_outputs(NUM_RECORDS + EXTRA_RECORDS);
		for (int k = 0; k < 5; k++) begin
			reg_read(int'(csa_pkg::IN_DATA_0) + k, word);
			check_word($sformatf("rdata IN_DATA_%0d", k), word, {24'h0, last_ch2_rec[8*k +: 8]});
		end
		reg_read(csa_pkg::OUT_ACC_LO, word);
		check_word("rdata OUT_ACC_LO", word, last_ch2_res.acc[31:0]);
		reg_read(csa_pkg::OUT_ACC_HI, word);
		check_word("rdata OUT_ACC_HI", word,
			{16'h0, last_ch2_res.channel, last_ch2_res.acc[39:32]});
		reg_write(csa_pkg::CHANNEL, 32'h0, 4'b1111);
		reg_read(csa_pkg::IN_VALID, word);
		check_word("rdata IN_VALID", word, 32'h0);
		reg_read(csa_pkg::OUT_VALID, word);
		check_word("rdata OUT_VALID", word, 32'h0);

		reg_read(12, word);
		check_word("rdata unmapped", word, 32'hE000_000C);

		repeat (30) @(negedge clk);
		if (exp_q.size() != 0 || out_count != sent_count) begin
			report_failure("results are missing at the end of the run");
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/csa_pkg.sv
rtl/csa_calc_unit.sv
rtl/csa_dispatch.sv
rtl/csa_collect.sv
rtl/csa_reg_port.sv
rtl/csa_top.sv
verif/csa_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f verilog.f --top-module csa_tb -o csa_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/csa_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1
